/* hdl/tiler_defs.svh */
// Array geometry and host register map shared by the tiler front end.
// Tile columns are derived from the array height and the pipeline depth.
`ifndef TILER_DEFS_SVH
`define TILER_DEFS_SVH

// Output rows covered by one tile
`define ARRAY_WIDTH 4

// Compute columns and pipeline registers in each of them
`define ARRAY_HEIGHT 4
`define PIPE_REGS 1

// Output columns covered by one tile
`define TILE_COLS (`ARRAY_HEIGHT * (`PIPE_REGS + 1))

// Element size in bytes, FP16 storage
`define ELEM_BYTES 2

// Host register map as 4-bit word indices
`define REG_X_ADDR  4'd0
`define REG_W_ADDR  4'd1
`define REG_Z_ADDR  4'd2
`define REG_SIZE_MK 4'd3
`define REG_SIZE_N  4'd4
`define REG_OPS     4'd5
`define REG_TRIGGER 4'd6
`define REG_STATUS  4'd7

`endif

/* hdl/tiler_pkg.sv */
// Job, configuration and tile types of the tiler front end.
// Leftover and extent widths assume a 4-row by 8-column tile.
package tiler_pkg;

  // Element-wise operation pairs selectable per job
  typedef enum logic [2:0] {
    MATMUL,
    GEMM,
    ADDMAX,
    ADDMIN,
    MULMAX,
    MULMIN,
    MAXMIN
  } gemm_op_e;

  typedef enum logic [1:0] {
    FLOAT16,
    FLOAT8,
    FLOAT16ALT,
    FLOAT8ALT
  } fmt_e;

  // Operation run by each floating-point stage
  typedef enum logic [1:0] {
    FPU_FMADD,
    FPU_ADD,
    FPU_MUL,
    FPU_MINMAX
  } fpu_op_e;

  typedef enum logic {
    RNE,
    RTZ
  } rnd_e;

  // Raw job as written by the host
  typedef struct packed {
    logic [31:0] x_addr;
    logic [31:0] w_addr;
    logic [31:0] z_addr;
    logic [15:0] m_size;
    logic [15:0] k_size;
    logic [15:0] n_size;
    gemm_op_e    gemm_ops;
    fmt_e        in_fmt;
    fmt_e        out_fmt;
  } job_t;

  typedef struct packed {
    job_t        job;
    logic [15:0] x_rows_iter;
    logic [15:0] x_cols_iter;
    logic [15:0] w_cols_iter;
    logic [15:0] w_rows_iter;
    // Leftovers are always below a full tile
    logic [2:0]  x_rows_lftovr;
    logic [3:0]  x_cols_lftovr;
    logic [3:0]  w_cols_lftovr;
    logic [31:0] x_d1_stride;
    logic [31:0] x_rows_offs;
    logic [31:0] w_d0_stride;
    logic [15:0] tot_stores;
    logic [31:0] tot_x_read;
    logic [31:0] w_tot_len;
    fpu_op_e     stage_1_op;
    fpu_op_e     stage_2_op;
    rnd_e        stage_1_rnd;
    rnd_e        stage_2_rnd;
    fmt_e        input_format;
    fmt_e        computing_format;
    logic        gemm_selection;
  } engine_cfg_t;

  // One output tile, rows and cols give the valid extent
  typedef struct packed {
    logic [15:0] row_idx;
    logic [15:0] col_idx;
    logic [31:0] x_addr;
    logic [31:0] w_addr;
    logic [31:0] z_addr;
    logic [2:0]  rows;
    logic [3:0]  cols;
    logic        last;
  } tile_t;

endpackage

/* hdl/job_regfile.sv */
// Job and trigger writes are dropped while busy, so the running job stays stable.
// The trigger register reads as zero and REG_STATUS returns busy in bit 0.
`include "tiler_defs.svh"

module job_regfile (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            clear_i,
  input  logic            reg_we_i,
  input  logic [3:0]      reg_addr_i,
  input  logic [31:0]     reg_wdata_i,
  output logic [31:0]     reg_rdata_o,
  input  logic            done_i,
  output tiler_pkg::job_t job_o,
  output logic            start_o,
  output logic            irq_o
);
  import tiler_pkg::*;

  job_t job_q;
  logic busy_q;
  logic start_q;
  logic irq_q;
  logic job_we;
  logic trigger;

  // Host writes only land while idle
  assign job_we  = reg_we_i && !busy_q;
  assign trigger = job_we && (reg_addr_i == `REG_TRIGGER);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      job_q <= '0;
    end else if (job_we) begin
      case (reg_addr_i)
        `REG_X_ADDR: job_q.x_addr <= reg_wdata_i;
        `REG_W_ADDR: job_q.w_addr <= reg_wdata_i;
        `REG_Z_ADDR: job_q.z_addr <= reg_wdata_i;
        `REG_SIZE_MK: begin
          job_q.m_size <= reg_wdata_i[15:0];
          job_q.k_size <= reg_wdata_i[31:16];
        end
        `REG_SIZE_N: job_q.n_size <= reg_wdata_i[15:0];
        `REG_OPS: begin
          job_q.gemm_ops <= gemm_op_e'(reg_wdata_i[2:0]);
          job_q.in_fmt   <= fmt_e'(reg_wdata_i[5:4]);
          job_q.out_fmt  <= fmt_e'(reg_wdata_i[9:8]);
        end
        default: begin
        end
      endcase
    end
  end

  // Busy spans from the accepted trigger to the sequencer's done
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q  <= 1'b0;
      start_q <= 1'b0;
      irq_q   <= 1'b0;
    end else if (clear_i) begin
      busy_q  <= 1'b0;
      start_q <= 1'b0;
      irq_q   <= 1'b0;
    end else begin
      start_q <= trigger;
      irq_q   <= done_i;
      if (trigger) begin
        busy_q <= 1'b1;
      end else if (done_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_comb begin
    case (reg_addr_i)
      `REG_X_ADDR:  reg_rdata_o = job_q.x_addr;
      `REG_W_ADDR:  reg_rdata_o = job_q.w_addr;
      `REG_Z_ADDR:  reg_rdata_o = job_q.z_addr;
      `REG_SIZE_MK: reg_rdata_o = {job_q.k_size, job_q.m_size};
      `REG_SIZE_N:  reg_rdata_o = {16'b0, job_q.n_size};
      `REG_OPS: begin
        reg_rdata_o = {22'b0, job_q.out_fmt, 2'b0, job_q.in_fmt, 1'b0, job_q.gemm_ops};
      end
      `REG_STATUS:  reg_rdata_o = {31'b0, busy_q};
      default:      reg_rdata_o = '0;
    endcase
  end

  assign job_o   = job_q;
  assign start_o = start_q;
  assign irq_o   = irq_q;

endmodule

/* hdl/gemm_tiler.sv */
// Configuration is valid three cycles after start and holds until setback or clear.
// tot_stores keeps 16 bits, so the tile count of a job must stay below 65536.
`include "tiler_defs.svh"

module gemm_tiler (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  logic                   setback_i,
  input  logic                   start_cfg_i,
  input  tiler_pkg::job_t        job_i,
  output logic                   cfg_valid_o,
  output tiler_pkg::engine_cfg_t cfg_o
);
  import tiler_pkg::*;

  localparam logic [15:0] tile_rows  = 16'(`ARRAY_WIDTH);
  localparam logic [15:0] tile_cols  = 16'(`TILE_COLS);
  localparam logic [15:0] col_rows   = 16'(`ARRAY_HEIGHT);
  localparam logic [31:0] elem_bytes = 32'(`ELEM_BYTES);

  logic [15:0] x_rows_base;
  logic [15:0] x_cols_base;
  logic [15:0] w_cols_base;
  logic [15:0] w_rows_base;
  logic [15:0] x_rows_rem;
  logic [15:0] x_cols_rem;
  logic [15:0] w_cols_rem;
  logic [15:0] w_rows_rem;
  logic [15:0] x_rows_iter;
  logic [15:0] x_cols_iter;
  logic [15:0] w_cols_iter;
  logic [15:0] w_rows_iter;
  logic [31:0] x_d1_stride;
  logic [31:0] w_d0_stride;

  logic        stage_a_valid_q;
  logic        stage_b_valid_q;
  logic        cfg_valid_q;
  logic [15:0] tot_stores_q;
  logic [31:0] tot_x_read_q;
  logic [31:0] w_tot_len_q;

  engine_cfg_t cfg_d;
  engine_cfg_t cfg_q;

  // Whole tiles along each dimension
  assign x_rows_base = job_i.m_size / tile_rows;
  assign x_cols_base = job_i.n_size / tile_cols;
  assign w_cols_base = job_i.k_size / tile_cols;
  assign w_rows_base = job_i.n_size / col_rows;

  assign x_rows_rem = job_i.m_size - x_rows_base * tile_rows;
  assign x_cols_rem = job_i.n_size - x_cols_base * tile_cols;
  assign w_cols_rem = job_i.k_size - w_cols_base * tile_cols;
  assign w_rows_rem = job_i.n_size - w_rows_base * col_rows;

  // A partial tile costs a full iteration
  assign x_rows_iter = (x_rows_rem != '0) ? x_rows_base + 16'd1 : x_rows_base;
  assign x_cols_iter = (x_cols_rem != '0) ? x_cols_base + 16'd1 : x_cols_base;
  assign w_cols_iter = (w_cols_rem != '0) ? w_cols_base + 16'd1 : w_cols_base;
  // W rows are padded up to whole compute columns
  assign w_rows_iter = (w_rows_rem != '0) ? job_i.n_size + col_rows - w_rows_rem
                                          : job_i.n_size;

  // Row strides in bytes of X and of W and Z
  assign x_d1_stride = elem_bytes * {16'b0, job_i.n_size};
  assign w_d0_stride = elem_bytes * {16'b0, job_i.k_size};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stage_a_valid_q <= 1'b0;
      stage_b_valid_q <= 1'b0;
      cfg_valid_q     <= 1'b0;
    end else if (clear_i || setback_i) begin
      stage_a_valid_q <= 1'b0;
      stage_b_valid_q <= 1'b0;
      cfg_valid_q     <= 1'b0;
    end else begin
      stage_a_valid_q <= start_cfg_i;
      stage_b_valid_q <= stage_a_valid_q;
      if (stage_b_valid_q) begin
        cfg_valid_q <= 1'b1;
      end
    end
  end

  // Products split over two stages to keep the multipliers short
  always_ff @(posedge clk_i) begin
    if (start_cfg_i) begin
      tot_stores_q <= x_rows_iter * w_cols_iter;
    end
    if (stage_a_valid_q) begin
      tot_x_read_q <= {16'b0, tot_stores_q} * {16'b0, x_cols_iter};
      w_tot_len_q  <= {16'b0, tot_stores_q} * {16'b0, w_rows_iter};
    end
  end

  always_comb begin
    cfg_d                  = '0;
    cfg_d.job              = job_i;
    cfg_d.x_rows_iter      = x_rows_iter;
    cfg_d.x_cols_iter      = x_cols_iter;
    cfg_d.w_cols_iter      = w_cols_iter;
    cfg_d.w_rows_iter      = w_rows_iter;
    cfg_d.x_rows_lftovr    = x_rows_rem[2:0];
    cfg_d.x_cols_lftovr    = x_cols_rem[3:0];
    cfg_d.w_cols_lftovr    = w_cols_rem[3:0];
    cfg_d.x_d1_stride      = x_d1_stride;
    cfg_d.x_rows_offs      = {16'b0, tile_rows} * x_d1_stride;
    cfg_d.w_d0_stride      = w_d0_stride;
    cfg_d.tot_stores       = tot_stores_q;
    cfg_d.tot_x_read       = tot_x_read_q;
    cfg_d.w_tot_len        = w_tot_len_q;
    // The second stage always reduces with min or max
    cfg_d.stage_2_op       = FPU_MINMAX;
    cfg_d.input_format     = job_i.in_fmt;
    cfg_d.computing_format = job_i.out_fmt;
    cfg_d.gemm_selection   = (job_i.gemm_ops != MATMUL);
    case (job_i.gemm_ops)
      MATMUL, GEMM: begin
        cfg_d.stage_1_op  = FPU_FMADD;
        cfg_d.stage_1_rnd = RNE;
        cfg_d.stage_2_rnd = RNE;
      end
      ADDMAX, ADDMIN: begin
        cfg_d.stage_1_op  = FPU_ADD;
        cfg_d.stage_1_rnd = RNE;
        cfg_d.stage_2_rnd = (job_i.gemm_ops == ADDMAX) ? RTZ : RNE;
      end
      MULMAX, MULMIN: begin
        cfg_d.stage_1_op  = FPU_MUL;
        cfg_d.stage_1_rnd = RNE;
        cfg_d.stage_2_rnd = (job_i.gemm_ops == MULMAX) ? RTZ : RNE;
      end
      MAXMIN: begin
        cfg_d.stage_1_op  = FPU_MINMAX;
        cfg_d.stage_1_rnd = RTZ;
        cfg_d.stage_2_rnd = RNE;
      end
      default: begin
        cfg_d.stage_1_op  = FPU_MINMAX;
        cfg_d.stage_1_rnd = RNE;
        cfg_d.stage_2_rnd = RTZ;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (stage_b_valid_q) begin
      cfg_q <= cfg_d;
    end
  end

  assign cfg_valid_o = cfg_valid_q;
  assign cfg_o       = cfg_q;

endmodule

/* hdl/tile_sequencer.sv */
// Emits one tile per cycle in row-major order with no back-pressure.
// A job of zero tiles ends at once with a bare done pulse.
`include "tiler_defs.svh"

module tile_sequencer (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  logic                   cfg_valid_i,
  input  tiler_pkg::engine_cfg_t cfg_i,
  output logic                   tile_valid_o,
  output tiler_pkg::tile_t       tile_o,
  output logic                   done_o
);
  import tiler_pkg::*;

  localparam logic [31:0] col_stride    = 32'(`TILE_COLS * `ELEM_BYTES);
  localparam logic [31:0] rows_per_tile = 32'(`ARRAY_WIDTH);
  localparam logic [2:0]  full_rows     = 3'(`ARRAY_WIDTH);
  localparam logic [3:0]  full_cols     = 4'(`TILE_COLS);

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DONE
  } state_e;

  state_e      state_q;
  logic [15:0] row_q;
  logic [15:0] col_q;
  logic        last_row;
  logic        last_col;
  logic        empty_job;
  logic        emit;
  logic        tile_valid_q;
  logic        done_q;
  logic [31:0] z_row_stride;
  tile_t       tile_d;
  tile_t       tile_q;

  assign last_row     = (row_q == cfg_i.x_rows_iter - 16'd1);
  assign last_col     = (col_q == cfg_i.w_cols_iter - 16'd1);
  assign empty_job    = (cfg_i.tot_stores == '0);
  // First tile leaves on the same edge that starts the run
  assign emit         = ((state_q == IDLE) && cfg_valid_i && !empty_job) || (state_q == RUN);
  assign z_row_stride = rows_per_tile * cfg_i.w_d0_stride;

  always_comb begin
    tile_d.row_idx = row_q;
    tile_d.col_idx = col_q;
    tile_d.x_addr  = cfg_i.job.x_addr + {16'b0, row_q} * cfg_i.x_rows_offs;
    tile_d.w_addr  = cfg_i.job.w_addr + {16'b0, col_q} * col_stride;
    tile_d.z_addr  = cfg_i.job.z_addr + {16'b0, row_q} * z_row_stride
                   + {16'b0, col_q} * col_stride;
    // Edge tiles shrink to the leftover when there is one
    tile_d.rows    = (last_row && cfg_i.x_rows_lftovr != '0) ? cfg_i.x_rows_lftovr : full_rows;
    tile_d.cols    = (last_col && cfg_i.w_cols_lftovr != '0) ? cfg_i.w_cols_lftovr : full_cols;
    tile_d.last    = last_row && last_col;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      row_q        <= '0;
      col_q        <= '0;
      tile_valid_q <= 1'b0;
      done_q       <= 1'b0;
    end else if (clear_i) begin
      state_q      <= IDLE;
      row_q        <= '0;
      col_q        <= '0;
      tile_valid_q <= 1'b0;
      done_q       <= 1'b0;
    end else begin
      tile_valid_q <= emit;
      done_q       <= (tile_valid_q && tile_q.last)
                   || ((state_q == IDLE) && cfg_valid_i && empty_job);
      case (state_q)
        IDLE: begin
          if (cfg_valid_i) begin
            state_q <= (empty_job || tile_d.last) ? DONE : RUN;
          end
        end
        RUN: begin
          if (tile_d.last) begin
            state_q <= DONE;
          end
        end
        // Hold until the tiler drops this job's configuration
        DONE: begin
          if (!cfg_valid_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
      if (emit) begin
        if (tile_d.last) begin
          row_q <= '0;
          col_q <= '0;
        end else if (last_col) begin
          row_q <= row_q + 16'd1;
          col_q <= '0;
        end else begin
          col_q <= col_q + 16'd1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (emit) begin
      tile_q <= tile_d;
    end
  end

  assign tile_valid_o = tile_valid_q;
  assign tile_o       = tile_q;
  assign done_o       = done_q;

endmodule

/* hdl/tiler_top.sv */
// Job front end: register file, configuration tiler and tile sequencer.
// The tile consumer must take one tile per cycle.
module tiler_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  logic                   reg_we_i,
  input  logic [3:0]             reg_addr_i,
  input  logic [31:0]            reg_wdata_i,
  output logic [31:0]            reg_rdata_o,
  output logic                   irq_o,
  output logic                   cfg_valid_o,
  output tiler_pkg::engine_cfg_t cfg_o,
  output logic                   tile_valid_o,
  output tiler_pkg::tile_t       tile_o
);
  import tiler_pkg::*;

  job_t job;
  logic start;
  logic done;

  job_regfile i_job_regfile (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .reg_we_i    (reg_we_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .done_i      (done),
    .job_o       (job),
    .start_o     (start),
    .irq_o       (irq_o)
  );

  // Done from the sequencer also retires the configuration
  gemm_tiler i_gemm_tiler (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .setback_i   (done),
    .start_cfg_i (start),
    .job_i       (job),
    .cfg_valid_o (cfg_valid_o),
    .cfg_o       (cfg_o)
  );

  tile_sequencer i_tile_sequencer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (clear_i),
    .cfg_valid_i  (cfg_valid_o),
    .cfg_i        (cfg_o),
    .tile_valid_o (tile_valid_o),
    .tile_o       (tile_o),
    .done_o       (done)
  );

endmodule

/* verif/tb_tiler_top.sv */
// Directed tests of the tiler front end against a reference model of configuration and tiles.
// The tile consumer is the monitor, which takes every tile in the cycle it appears.
`include "tiler_defs.svh"

module tb_tiler_top;
  timeunit 1ns;
  timeprecision 100ps;
  import tiler_pkg::*;

  // Jobs take about 800 cycles in total and the largest has 50 tiles
  localparam int unsigned TIMEOUT_CYCLES = 2000;

  logic        clk_i;
  logic        rst_ni;
  logic        clear_i;
  logic        reg_we_i;
  logic [3:0]  reg_addr_i;
  logic [31:0] reg_wdata_i;
  logic [31:0] reg_rdata_o;
  logic        irq_o;
  logic        cfg_valid_o;
  engine_cfg_t cfg_o;
  logic        tile_valid_o;
  tile_t       tile_o;

  int unsigned cycles = 0;
  int unsigned mismatches = 0;
  int unsigned other_errors = 0;
  logic [31:0] lfsr_q;

  // Filled by the monitor at each falling edge
  tile_t       tiles_q[$];
  int unsigned tile_cycles_q[$];
  int unsigned irq_count = 0;
  int unsigned irq_cycle = 0;
  int unsigned cfg_valid_cycles = 0;
  int unsigned cfg_fall_cycle = 0;
  logic        cfg_seen = 1'b0;
  logic        cfg_valid_prev = 1'b0;
  engine_cfg_t cfg_got;

  tiler_top dut_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (clear_i),
    .reg_we_i     (reg_we_i),
    .reg_addr_i   (reg_addr_i),
    .reg_wdata_i  (reg_wdata_i),
    .reg_rdata_o  (reg_rdata_o),
    .irq_o        (irq_o),
    .cfg_valid_o  (cfg_valid_o),
    .cfg_o        (cfg_o),
    .tile_valid_o (tile_valid_o),
    .tile_o       (tile_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Error: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  always @(negedge clk_i) begin
    if (tile_valid_o) begin
      tiles_q.push_back(tile_o);
      tile_cycles_q.push_back(cycles);
    end
    if (irq_o) begin
      irq_count++;
      irq_cycle = cycles;
    end
    if (cfg_valid_o) begin
      cfg_valid_cycles++;
      if (!cfg_seen) begin
        cfg_got  = cfg_o;
        cfg_seen = 1'b1;
      end
    end
    if (cfg_valid_prev && !cfg_valid_o) begin
      cfg_fall_cycle = cycles;
    end
    cfg_valid_prev = cfg_valid_o;
  end

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("Fail %0t %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_cfg(input string name, input engine_cfg_t got, input engine_cfg_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("Fail %0t %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_tile(input string name, input tile_t got, input tile_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("Fail %0t %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic flag_error(input string msg);
    other_errors++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  // Galois LFSR over x^32 + x^22 + x^2 + x + 1 stepped once per bit
  function automatic logic [31:0] lfsr_take(input int nbits);
    logic [31:0] v;
    logic        b;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      b = lfsr_q[0];
      lfsr_q = lfsr_q >> 1;
      if (b) begin
        lfsr_q = lfsr_q ^ 32'h8020_0003;
      end
      v = {v[30:0], b};
    end
    return v;
  endfunction

  function automatic job_t make_job(input logic [31:0] x, input logic [31:0] w,
                                    input logic [31:0] z, input int unsigned m,
                                    input int unsigned n, input int unsigned k,
                                    input gemm_op_e op, input fmt_e fin, input fmt_e fout);
    job_t j;
    j.x_addr   = x;
    j.w_addr   = w;
    j.z_addr   = z;
    j.m_size   = 16'(m);
    j.n_size   = 16'(n);
    j.k_size   = 16'(k);
    j.gemm_ops = op;
    j.in_fmt   = fin;
    j.out_fmt  = fout;
    return j;
  endfunction

  // Operation code in bits 2:0, input format in 5:4, output format in 9:8
  function automatic logic [31:0] ops_word(input job_t j);
    logic [31:0] w;
    w       = '0;
    w[2:0]  = j.gemm_ops;
    w[5:4]  = j.in_fmt;
    w[9:8]  = j.out_fmt;
    return w;
  endfunction

  function automatic engine_cfg_t model_cfg(input job_t j);
    engine_cfg_t c;
    int unsigned m;
    int unsigned n;
    int unsigned k;
    int unsigned tiles;
    m = j.m_size;
    n = j.n_size;
    k = j.k_size;
    c = '0;
    c.job           = j;
    c.x_rows_iter   = 16'((m + `ARRAY_WIDTH - 1) / `ARRAY_WIDTH);
    c.x_cols_iter   = 16'((n + `TILE_COLS - 1) / `TILE_COLS);
    c.w_cols_iter   = 16'((k + `TILE_COLS - 1) / `TILE_COLS);
    c.w_rows_iter   = 16'(((n + `ARRAY_HEIGHT - 1) / `ARRAY_HEIGHT) * `ARRAY_HEIGHT);
    c.x_rows_lftovr = 3'(m % `ARRAY_WIDTH);
    c.x_cols_lftovr = 4'(n % `TILE_COLS);
    c.w_cols_lftovr = 4'(k % `TILE_COLS);
    c.x_d1_stride   = `ELEM_BYTES * n;
    c.w_d0_stride   = `ELEM_BYTES * k;
    c.x_rows_offs   = `ARRAY_WIDTH * `ELEM_BYTES * n;
    tiles           = c.x_rows_iter * c.w_cols_iter;
    c.tot_stores    = 16'(tiles);
    c.tot_x_read    = tiles * c.x_cols_iter;
    c.w_tot_len     = tiles * c.w_rows_iter;
    // Stage 2 reduces with min or max and the max variants round toward zero
    c.stage_2_op     = FPU_MINMAX;
    c.stage_1_rnd    = RNE;
    c.stage_2_rnd    = RNE;
    c.gemm_selection = 1'b1;
    case (j.gemm_ops)
      MATMUL: begin
        c.stage_1_op     = FPU_FMADD;
        c.gemm_selection = 1'b0;
      end
      GEMM:   c.stage_1_op = FPU_FMADD;
      ADDMIN: c.stage_1_op = FPU_ADD;
      MULMIN: c.stage_1_op = FPU_MUL;
      ADDMAX: begin
        c.stage_1_op  = FPU_ADD;
        c.stage_2_rnd = RTZ;
      end
      MULMAX: begin
        c.stage_1_op  = FPU_MUL;
        c.stage_2_rnd = RTZ;
      end
      default: begin
        c.stage_1_op  = FPU_MINMAX;
        c.stage_1_rnd = RTZ;
      end
    endcase
    c.input_format     = j.in_fmt;
    c.computing_format = j.out_fmt;
    return c;
  endfunction

  function automatic tile_t model_tile(input engine_cfg_t c, input int unsigned r,
                                       input int unsigned col);
    tile_t t;
    logic  last_r;
    logic  last_c;
    last_r    = (r == c.x_rows_iter - 1);
    last_c    = (col == c.w_cols_iter - 1);
    t.row_idx = 16'(r);
    t.col_idx = 16'(col);
    t.x_addr  = c.job.x_addr + r * c.x_rows_offs;
    t.w_addr  = c.job.w_addr + col * `TILE_COLS * `ELEM_BYTES;
    t.z_addr  = c.job.z_addr + r * `ARRAY_WIDTH * c.w_d0_stride
              + col * `TILE_COLS * `ELEM_BYTES;
    t.rows    = (last_r && c.x_rows_lftovr != 0) ? c.x_rows_lftovr : 3'(`ARRAY_WIDTH);
    t.cols    = (last_c && c.w_cols_lftovr != 0) ? c.w_cols_lftovr : 4'(`TILE_COLS);
    t.last    = last_r && last_c;
    return t;
  endfunction

  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
    reg_we_i    = 1'b1;
    reg_addr_i  = addr;
    reg_wdata_i = data;
    step();
    reg_we_i = 1'b0;
  endtask

  // Read data is combinational and is sampled well before the next edge
  task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
    reg_addr_i = addr;
    #0.5;
    data = reg_rdata_o;
  endtask

  task automatic write_job(input job_t j);
    write_reg(`REG_X_ADDR, j.x_addr);
    write_reg(`REG_W_ADDR, j.w_addr);
    write_reg(`REG_Z_ADDR, j.z_addr);
    write_reg(`REG_SIZE_MK, {j.k_size, j.m_size});
    write_reg(`REG_SIZE_N, {16'b0, j.n_size});
    write_reg(`REG_OPS, ops_word(j));
  endtask

  task automatic start_job(input job_t j, output int unsigned trig_cycle);
    write_job(j);
    tiles_q.delete();
    tile_cycles_q.delete();
    cfg_seen   = 1'b0;
    trig_cycle = cycles + 1;
    write_reg(`REG_TRIGGER, 32'd1);
  endtask

  task automatic finish_job(input engine_cfg_t exp, input int unsigned trig_cycle,
                            input int unsigned irq_base);
    logic [31:0] rd;
    int unsigned n_tiles;
    n_tiles = exp.tot_stores;
    while (irq_count == irq_base) begin
      step();
    end
    if (!cfg_seen) begin
      flag_error("cfg_valid_o never rose during the job");
    end
    check_cfg("cfg_o", cfg_got, exp);
    check_word("tile count", tiles_q.size(), n_tiles);
    for (int unsigned idx = 0; idx < tiles_q.size() && idx < n_tiles; idx++) begin
      check_tile("tile_o", tiles_q[idx],
                 model_tile(exp, idx / exp.w_cols_iter, idx % exp.w_cols_iter));
      check_word("tile cycle", tile_cycles_q[idx], trig_cycle + 4 + idx);
    end
    check_word("irq cycle", irq_cycle, trig_cycle + n_tiles + 5);
    check_word("cfg_valid fall cycle", cfg_fall_cycle, irq_cycle);
    read_reg(`REG_STATUS, rd);
    check_word("status after done", rd, 32'd0);
  endtask

  task automatic run_job(input job_t j);
    int unsigned trig_cycle;
    int unsigned irq_base;
    irq_base = irq_count;
    start_job(j, trig_cycle);
    finish_job(model_cfg(j), trig_cycle, irq_base);
  endtask

  task automatic test_reset_idle();
    logic [31:0] rd;
    repeat (20) step();
    if (tiles_q.size() != 0) begin
      flag_error("tile emitted before any trigger");
    end
    if (cfg_valid_cycles != 0) begin
      flag_error("cfg_valid_o went high before any trigger");
    end
    if (irq_count != 0) begin
      flag_error("irq_o pulsed before any trigger");
    end
    read_reg(`REG_STATUS, rd);
    check_word("status after reset", rd, 32'd0);
  endtask

  task automatic test_exact_job();
    run_job(make_job(32'h1000_0000, 32'h2000_0000, 32'h3000_0000, 8, 16, 16,
                     MATMUL, FLOAT16, FLOAT16));
  endtask

  task automatic test_leftover_jobs();
    int unsigned m;
    int unsigned n;
    int unsigned k;
    repeat (8) begin
      m = lfsr_take(6) % 40 + 1;
      n = lfsr_take(6) % 40 + 1;
      k = lfsr_take(6) % 40 + 1;
      run_job(make_job({16'(lfsr_take(16)), 16'h0}, {16'(lfsr_take(16)), 16'h0},
                       {16'(lfsr_take(16)), 16'h0}, m, n, k, GEMM, FLOAT16ALT, FLOAT8));
    end
  endtask

  // Single-tile jobs for each operation pair with the formats cycling
  task automatic test_decode();
    for (int op = 0; op <= 6; op++) begin
      run_job(make_job(32'h0000_4000, 32'h0000_8000, 32'h0000_c000, 4, 8, 8,
                       gemm_op_e'(op), fmt_e'(op % 4), fmt_e'((op + 1) % 4)));
    end
  endtask

  task automatic test_busy_writes();
    job_t        j;
    logic [31:0] rd;
    int unsigned trig_cycle;
    int unsigned irq_base;
    j = make_job(32'h1111_0000, 32'h2222_0100, 32'h3333_0200, 12, 20, 24,
                 GEMM, FLOAT8, FLOAT16ALT);
    write_job(j);
    read_reg(`REG_X_ADDR, rd);
    check_word("x_addr readback", rd, j.x_addr);
    read_reg(`REG_W_ADDR, rd);
    check_word("w_addr readback", rd, j.w_addr);
    read_reg(`REG_Z_ADDR, rd);
    check_word("z_addr readback", rd, j.z_addr);
    read_reg(`REG_SIZE_MK, rd);
    check_word("size_mk readback", rd, {j.k_size, j.m_size});
    read_reg(`REG_SIZE_N, rd);
    check_word("size_n readback", rd, {16'b0, j.n_size});
    read_reg(`REG_OPS, rd);
    check_word("ops readback", rd, ops_word(j));
    irq_base = irq_count;
    start_job(j, trig_cycle);
    read_reg(`REG_STATUS, rd);
    check_word("status while busy", rd, 32'd1);
    write_reg(`REG_X_ADDR, 32'hdead_0000);
    write_reg(`REG_SIZE_MK, {16'd3, 16'd5});
    write_reg(`REG_TRIGGER, 32'd1);
    finish_job(model_cfg(j), trig_cycle, irq_base);
    read_reg(`REG_X_ADDR, rd);
    check_word("x_addr after busy write", rd, j.x_addr);
  endtask

  task automatic test_clear();
    logic [31:0] rd;
    int unsigned trig_cycle;
    int unsigned n_seen;
    int unsigned irq_base;
    start_job(make_job(32'h4000_0000, 32'h5000_0000, 32'h6000_0000, 40, 40, 40,
                       ADDMAX, FLOAT16, FLOAT16), trig_cycle);
    while (tiles_q.size() < 5) begin
      step();
    end
    clear_i = 1'b1;
    step();
    clear_i = 1'b0;
    if (tile_valid_o !== 1'b0) begin
      flag_error("tile_valid_o still high after clear");
    end
    if (cfg_valid_o !== 1'b0) begin
      flag_error("cfg_valid_o still high after clear");
    end
    read_reg(`REG_STATUS, rd);
    check_word("status after clear", rd, 32'd0);
    n_seen   = tiles_q.size();
    irq_base = irq_count;
    repeat (20) step();
    if (tiles_q.size() != n_seen) begin
      flag_error("tiles kept coming after clear");
    end
    if (irq_count != irq_base) begin
      flag_error("irq_o pulsed for a cleared job");
    end
    run_job(make_job(32'h0001_0000, 32'h0002_0000, 32'h0003_0000, 9, 10, 17,
                     MULMIN, FLOAT8ALT, FLOAT16));
  endtask

  initial begin
    rst_ni      = 1'b0;
    clear_i     = 1'b0;
    reg_we_i    = 1'b0;
    reg_addr_i  = '0;
    reg_wdata_i = '0;
    lfsr_q      = 32'h7175;
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    test_reset_idle();
    test_exact_job();
    test_leftover_jobs();
    test_decode();
    test_busy_writes();
    test_clear();
    $display("Checks done: %0d value mismatches, %0d other errors", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+hdl
hdl/tiler_pkg.sv
hdl/job_regfile.sv
hdl/gemm_tiler.sv
hdl/tile_sequencer.sv
hdl/tiler_top.sv
verif/tb_tiler_top.sv

/* Bender.yml */
package:
  name: gemm_tiler_front

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/tiler_pkg.sv
      - hdl/job_regfile.sv
      - hdl/gemm_tiler.sv
      - hdl/tile_sequencer.sv
      - hdl/tiler_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/tb_tiler_top.sv
